//--- logic/vred_pkg.sv
// Only the low 6 address bits select a register, so the map repeats every 64 bytes
package vred_pkg;

  ////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////
  typedef logic [31:0]  word_t;    // AXI data word
  typedef logic [127:0] vec_t;     // Source vector of two 64-bit lanes
  typedef logic [63:0]  elem_t;    // Scalar and result
  typedef logic [1:0]   sew_t;     // Element width code
  typedef logic [1:0]   red_op_t;  // Reduction code
  typedef logic [5:0]   reg_off_t; // Decoded byte offset

  localparam sew_t SEW_8  = 2'd0;
  localparam sew_t SEW_16 = 2'd1;
  localparam sew_t SEW_32 = 2'd2;
  localparam sew_t SEW_64 = 2'd3;

  localparam red_op_t RED_SUM = 2'd0;
  localparam red_op_t RED_AND = 2'd1;
  localparam red_op_t RED_OR  = 2'd2;
  localparam red_op_t RED_XOR = 2'd3;

  localparam logic [1:0] AXI_OKAY = 2'b00;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  localparam reg_off_t OFF_CFG       = 6'h00;
  localparam reg_off_t OFF_SCALAR_LO = 6'h04;
  localparam reg_off_t OFF_SCALAR_HI = 6'h08;
  localparam reg_off_t OFF_VS2_0     = 6'h10;
  localparam reg_off_t OFF_VS2_1     = 6'h14;
  localparam reg_off_t OFF_VS2_2     = 6'h18;
  localparam reg_off_t OFF_VS2_3     = 6'h1C;
  localparam reg_off_t OFF_START     = 6'h20; // Write only
  localparam reg_off_t OFF_STATUS    = 6'h24; // Read only
  localparam reg_off_t OFF_RES_LO    = 6'h28;
  localparam reg_off_t OFF_RES_HI    = 6'h2C;

  typedef enum logic [1:0] {IDLE, ISSUE, CAPTURE} ctrl_state_e;

  // Keeps only the bits of one element
  function automatic elem_t sew_mask(sew_t sew);
    unique case (sew)
      SEW_8:   return 64'h0000_0000_0000_00FF;
      SEW_16:  return 64'h0000_0000_0000_FFFF;
      SEW_32:  return 64'h0000_0000_FFFF_FFFF;
      default: return 64'hFFFF_FFFF_FFFF_FFFF;
    endcase
  endfunction

  // One reduction step with carries above the element masked off later
  function automatic elem_t red_apply(red_op_t op, elem_t a, elem_t b);
    unique case (op)
      RED_SUM: return a + b;
      RED_AND: return a & b;
      RED_OR:  return a | b;
      default: return a ^ b;
    endcase
  endfunction

endpackage

//--- logic/vred_unit.sv
// Fixed latency of one cycle with no stall; data_fu_i must already hold the combined element 0
module vred_unit import vred_pkg::*; (
  input  logic    clk_i,
  input  logic    rstn_i,
  input  red_op_t op_i,        // Reduction code
  input  sew_t    sew_i,       // Element width
  input  vec_t    data_fu_i,   // Combined element 0 in the low element
  input  vec_t    data_vs2_i,  // Source vector
  output elem_t   red_data_o   // Zero-extended reduction
);

  ////////////////////////////////////////////////////////////
  // Stage 0 merges element 0
  ////////////////////////////////////////////////////////////
  vec_t data_vs_0;

  always_comb begin
    unique case (sew_i)
      SEW_8:   data_vs_0 = {data_vs2_i[127:8], data_fu_i[7:0]};
      SEW_16:  data_vs_0 = {data_vs2_i[127:16], data_fu_i[15:0]};
      SEW_32:  data_vs_0 = {data_vs2_i[127:32], data_fu_i[31:0]};
      default: data_vs_0 = {data_vs2_i[127:64], data_fu_i[63:0]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Stage 0 to stage 1 register
  ////////////////////////////////////////////////////////////
  red_op_t op_1;
  sew_t    sew_1;
  vec_t    data_vs_1;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      op_1  <= RED_SUM;
      sew_1 <= SEW_8;
    end else begin
      op_1  <= op_i;
      sew_1 <= sew_i;
    end
  end

  // Merged vector for stage 1
  always_ff @(posedge clk_i) begin
    data_vs_1 <= data_vs_0;
  end

  ////////////////////////////////////////////////////////////
  // Stage 1 pairwise fold
  ////////////////////////////////////////////////////////////
  elem_t lvl [16];  // Elements of the current tree level

  always_comb begin
    int unsigned n;
    n = 16 >> sew_1;  // Element count at this width
    lvl = '{default: '0};

    // Unpack elements zero-extended to 64 bits
    unique case (sew_1)
      SEW_8: begin
        for (int i = 0; i < 16; i++) lvl[i] = elem_t'(data_vs_1[i*8 +: 8]);
      end
      SEW_16: begin
        for (int i = 0; i < 8; i++) lvl[i] = elem_t'(data_vs_1[i*16 +: 16]);
      end
      SEW_32: begin
        for (int i = 0; i < 4; i++) lvl[i] = elem_t'(data_vs_1[i*32 +: 32]);
      end
      default: begin
        for (int i = 0; i < 2; i++) lvl[i] = data_vs_1[i*64 +: 64];
      end
    endcase

    // Four levels cover 16 elements and narrower trees idle in the upper levels
    for (int l = 0; l < 4; l++) begin
      for (int i = 0; i < 8; i++) begin
        if (i < n / 2) begin
          lvl[i] = red_apply(op_1, lvl[2*i], lvl[2*i+1]);
        end
      end
      if (n > 1) begin
        n = n / 2;
      end
    end
  end

  assign red_data_o = lvl[0] & sew_mask(sew_1);  // Truncate then zero-extend

endmodule

//--- logic/vred_ctrl.sv
// Start pulses while busy are dropped; operands must stay stable only through the ISSUE cycle
module vred_ctrl import vred_pkg::*; (
  input  logic    clk_i,
  input  logic    rstn_i,
  input  logic    start_i,      // One-cycle launch request
  input  red_op_t op_i,
  input  sew_t    sew_i,
  input  elem_t   scalar_i,     // Start value
  input  vec_t    vec_i,        // Source vector
  input  elem_t   red_data_i,   // Unit output, valid in CAPTURE
  output red_op_t unit_op_o,
  output sew_t    unit_sew_o,
  output vec_t    unit_fu_o,
  output vec_t    unit_vs2_o,
  output logic    busy_o,
  output logic    done_o,
  output elem_t   result_o
);

  ctrl_state_e state_q, state_d;
  logic        issue;
  elem_t       mask;
  elem_t       elem0;     // Scalar folded with element 0
  logic        done_q;
  elem_t       result_q;

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (start_i) state_d = ISSUE;
      ISSUE:   state_d = CAPTURE;  // Unit registers operands at this edge
      CAPTURE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q  <= IDLE;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start_i) begin
        done_q <= 1'b0;                // Accepted start clears done
      end else if (state_q == CAPTURE) begin
        done_q   <= 1'b1;
        result_q <= red_data_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Element 0 combine done by the functional unit
  ////////////////////////////////////////////////////////////
  assign issue = (state_q == ISSUE);
  assign mask  = sew_mask(sew_i);
  assign elem0 = red_apply(op_i, scalar_i & mask, vec_i[63:0] & mask) & mask;

  // Operands only toggle the unit during ISSUE
  assign unit_op_o  = issue ? op_i : RED_SUM;
  assign unit_sew_o = issue ? sew_i : SEW_8;
  assign unit_fu_o  = issue ? {64'h0, elem0} : '0;
  assign unit_vs2_o = issue ? vec_i : '0;

  assign busy_o   = (state_q != IDLE);
  assign done_o   = done_q;
  assign result_o = result_q;

endmodule

//--- logic/vred_axil_regs.sv
// Every write is a full word with no strobes, responses are always OKAY and unmapped reads give zero
module vred_axil_regs import vred_pkg::*; #(
  parameter int ADDR_W = 8  // 6 or more
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  // AXI4-Lite slave
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  word_t             wdata_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic              bvalid_o,
  output logic [1:0]        bresp_o,
  input  logic              bready_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic              rvalid_o,
  output word_t             rdata_o,
  output logic [1:0]        rresp_o,
  input  logic              rready_i,
  // Controller side
  output red_op_t           op_o,
  output sew_t              sew_o,
  output elem_t             scalar_o,
  output vec_t              vec_o,
  output logic              start_o,
  input  logic              busy_i,
  input  logic              done_i,
  input  elem_t             result_i
);

  logic     wr_ready_q;   // Shared by AW and W
  logic     bvalid_q;
  logic     arready_q;
  logic     rvalid_q;
  logic     rvalid_d;
  word_t    rdata_q;
  word_t    rd_word;
  logic     wr_en;
  logic     rd_en;
  reg_off_t waddr;
  reg_off_t raddr;

  red_op_t  op_q;
  sew_t     sew_q;
  elem_t    scalar_q;
  vec_t     vec_q;

  assign waddr = awaddr_i[5:0];
  assign raddr = araddr_i[5:0];
  assign wr_en = wr_ready_q & awvalid_i & wvalid_i;
  assign rd_en = arready_q & arvalid_i;

  ////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
    end else begin
      // One-cycle ready once address and data are both present
      wr_ready_q <= awvalid_i & wvalid_i & ~bvalid_q & ~wr_ready_q;
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      op_q     <= RED_SUM;
      sew_q    <= SEW_8;
      scalar_q <= '0;
      vec_q    <= '0;
    end else if (wr_en) begin
      unique case (waddr)
        OFF_CFG: begin
          op_q  <= wdata_i[1:0];
          sew_q <= wdata_i[3:2];
        end
        OFF_SCALAR_LO: scalar_q[31:0]  <= wdata_i;
        OFF_SCALAR_HI: scalar_q[63:32] <= wdata_i;
        OFF_VS2_0:     vec_q[31:0]     <= wdata_i;
        OFF_VS2_1:     vec_q[63:32]    <= wdata_i;
        OFF_VS2_2:     vec_q[95:64]    <= wdata_i;
        OFF_VS2_3:     vec_q[127:96]   <= wdata_i;
        default: ;                       // START and read-only offsets
      endcase
    end
  end

  assign start_o = wr_en && (waddr == OFF_START);  // Same cycle as the handshake

  ////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////
  always_comb begin
    unique case (raddr)
      OFF_CFG:       rd_word = {28'h0, sew_q, op_q};
      OFF_SCALAR_LO: rd_word = scalar_q[31:0];
      OFF_SCALAR_HI: rd_word = scalar_q[63:32];
      OFF_VS2_0:     rd_word = vec_q[31:0];
      OFF_VS2_1:     rd_word = vec_q[63:32];
      OFF_VS2_2:     rd_word = vec_q[95:64];
      OFF_VS2_3:     rd_word = vec_q[127:96];
      OFF_STATUS:    rd_word = {30'h0, done_i, busy_i};
      OFF_RES_LO:    rd_word = result_i[31:0];
      OFF_RES_HI:    rd_word = result_i[63:32];
      default:       rd_word = '0;
    endcase
  end

  always_comb begin
    rvalid_d = rvalid_q;
    if (rd_en) begin
      rvalid_d = 1'b1;
    end else if (rvalid_q && rready_i) begin
      rvalid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      arready_q <= ~rvalid_d;  // Open again once the response is taken
      rvalid_q  <= rvalid_d;
      if (rd_en) begin
        rdata_q <= rd_word;    // Held until rready
      end
    end
  end

  assign awready_o = wr_ready_q;
  assign wready_o  = wr_ready_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = AXI_OKAY;
  assign arready_o = arready_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = AXI_OKAY;

  assign op_o     = op_q;
  assign sew_o    = sew_q;
  assign scalar_o = scalar_q;
  assign vec_o    = vec_q;

endmodule

//--- logic/vred_top.sv
// One AXI4-Lite host and one reduction in flight; done is seen 3 cycles after the START write
module vred_top import vred_pkg::*; #(
  parameter int ADDR_W = 8  // 6 or more
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  word_t             wdata_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic              bvalid_o,
  output logic [1:0]        bresp_o,
  input  logic              bready_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic              rvalid_o,
  output word_t             rdata_o,
  output logic [1:0]        rresp_o,
  input  logic              rready_i
);

  // Register file to controller
  red_op_t cfg_op;
  sew_t    cfg_sew;
  elem_t   cfg_scalar;
  vec_t    cfg_vec;
  logic    start;
  logic    busy;
  logic    done;
  elem_t   result;

  // Controller to reduction unit
  red_op_t unit_op;
  sew_t    unit_sew;
  vec_t    unit_fu;
  vec_t    unit_vs2;
  elem_t   red_data;

  vred_axil_regs #(
    .ADDR_W (ADDR_W)
  ) vred_axil_regs_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bresp_o   (bresp_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rready_i  (rready_i),
    .op_o      (cfg_op),
    .sew_o     (cfg_sew),
    .scalar_o  (cfg_scalar),
    .vec_o     (cfg_vec),
    .start_o   (start),
    .busy_i    (busy),
    .done_i    (done),
    .result_i  (result)
  );

  vred_ctrl vred_ctrl_inst (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .start_i    (start),
    .op_i       (cfg_op),
    .sew_i      (cfg_sew),
    .scalar_i   (cfg_scalar),
    .vec_i      (cfg_vec),
    .red_data_i (red_data),
    .unit_op_o  (unit_op),
    .unit_sew_o (unit_sew),
    .unit_fu_o  (unit_fu),
    .unit_vs2_o (unit_vs2),
    .busy_o     (busy),
    .done_o     (done),
    .result_o   (result)
  );

  vred_unit vred_unit_inst (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .op_i       (unit_op),
    .sew_i      (unit_sew),
    .data_fu_i  (unit_fu),
    .data_vs2_i (unit_vs2),
    .red_data_o (red_data)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Clock runs from time zero; reset is low from the start and released on a falling edge
module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rstn_o = 1'b1;
  end

endmodule

//--- testbench/vred_properties.sv
// Bound into vred_top; each failing assertion raises $error and adds to fail_count
module vred_properties import vred_pkg::*; (
  input logic       clk_i,
  input logic       rstn_i,
  input logic       bvalid_i,
  input logic       bready_i,
  input logic       rvalid_i,
  input logic       rready_i,
  input word_t      rdata_i,
  input logic       busy_i,
  input logic       done_i
);

  int unsigned fail_count = 0;  // Watched by the testbench

  ////////////////////////////////////////////////////////////
  // AXI response channels
  ////////////////////////////////////////////////////////////
  b_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      $error("rvalid dropped or rdata changed before rready");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // Controller flags
  ////////////////////////////////////////////////////////////
  flags_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(busy_i && done_i))
    else begin
      $error("busy and done high together");
      fail_count++;
    end

  busy_two_cycles: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(busy_i) |=> busy_i ##1 !busy_i)  // ISSUE then CAPTURE
    else begin
      $error("busy did not last exactly 2 cycles");
      fail_count++;
    end

endmodule

bind vred_top vred_properties vred_properties_inst (
  .clk_i    (clk_i),
  .rstn_i   (rstn_i),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i),
  .rdata_i  (rdata_o),
  .busy_i   (busy),
  .done_i   (done)
);

//--- testbench/tb_vred_top.sv
// Inputs change 5 units after a rising edge and outputs are sampled there; needs vred_properties
module tb_vred_top import vred_pkg::*; ();

  localparam int    ADDR_W         = 8;
  localparam int    DRIVE_DLY      = 5;
  localparam int    TIMEOUT_CYCLES = 4000;  // Full run is well under half of this
  localparam word_t RESP_OKAY      = 32'h0;

  logic              clk;
  logic              rstn;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  word_t             wdata;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic [1:0]        bresp;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic              rvalid;
  word_t             rdata;
  logic [1:0]        rresp;
  logic              rready;
  int unsigned       cycle_count = 0;

  tb_clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (3)
  ) tb_clock_gen_inst (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  vred_top #(
    .ADDR_W (ADDR_W)
  ) vred_top_inst (
    .clk_i     (clk),
    .rstn_i    (rstn),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bresp_o   (bresp),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rready_i  (rready)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
      abort_run("register value mismatch");
    end
  endtask

  task automatic check_result(input string what, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s gave %h, expected %h", $time, what, got, exp);
      abort_run("reduction result mismatch");
    end
  endtask

  // Fold over the scalar and every element at the element width
  function automatic elem_t ref_fold(red_op_t op, sew_t sew, elem_t scalar, vec_t vec);
    int unsigned bits;
    elem_t       mask;
    elem_t       acc;
    elem_t       e;
    vec_t        shifted;
    bits = 8 << sew;
    mask = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
    acc  = scalar & mask;
    for (int i = 0; i < 128 / bits; i++) begin
      shifted = vec >> (i * bits);
      e       = shifted[63:0] & mask;
      case (op)
        RED_SUM: acc = (acc + e) & mask;
        RED_AND: acc = acc & e;
        RED_OR:  acc = acc | e;
        default: acc = acc ^ e;
      endcase
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////
  // AXI4-Lite bus tasks
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input word_t data,
                            input int unsigned resp_dly);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    while (!(awready && wready)) next_cycle();
    next_cycle();                    // Handshake edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) next_cycle();
    repeat (resp_dly) next_cycle();  // bready held low
    check_word("BRESP", word_t'(bresp), RESP_OKAY);
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, input int unsigned ready_dly,
                           output word_t data);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) next_cycle();
    next_cycle();
    arvalid = 1'b0;
    while (!rvalid) next_cycle();
    data = rdata;
    repeat (ready_dly) begin
      next_cycle();
      check_word("RDATA under back-pressure", rdata, data);
    end
    check_word("RRESP", word_t'(rresp), RESP_OKAY);
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic expect_read(input logic [ADDR_W-1:0] addr, input word_t exp);
    word_t got;
    axil_read(addr, 0, got);
    check_word($sformatf("offset %h", addr), got, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // Reduction helpers
  ////////////////////////////////////////////////////////////
  task automatic load_operands(input red_op_t op, input sew_t sew, input elem_t scalar,
                               input vec_t vec);
    axil_write(OFF_CFG, {28'h0, sew, op}, 0);
    axil_write(OFF_SCALAR_LO, scalar[31:0], 0);
    axil_write(OFF_SCALAR_HI, scalar[63:32], 0);
    axil_write(OFF_VS2_0, vec[31:0], 0);
    axil_write(OFF_VS2_1, vec[63:32], 0);
    axil_write(OFF_VS2_2, vec[95:64], 0);
    axil_write(OFF_VS2_3, vec[127:96], 0);
  endtask

  task automatic wait_done();
    word_t status;
    status = '0;
    while (!status[1]) axil_read(OFF_STATUS, 0, status);
  endtask

  task automatic read_result(input int unsigned ready_dly, output elem_t res);
    word_t lo;
    word_t hi;
    axil_read(OFF_RES_LO, ready_dly, lo);
    axil_read(OFF_RES_HI, ready_dly, hi);
    res = {hi, lo};
  endtask

  task automatic run_reduction(input red_op_t op, input sew_t sew, input elem_t scalar,
                               input vec_t vec);
    elem_t res;
    load_operands(op, sew, scalar, vec);
    axil_write(OFF_START, 32'h0, 0);
    wait_done();
    read_result(0, res);
    check_result($sformatf("op %0d sew %0d", op, sew), res, ref_fold(op, sew, scalar, vec));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_values();
    expect_read(OFF_CFG, 32'h0);
    expect_read(OFF_SCALAR_LO, 32'h0);
    expect_read(OFF_SCALAR_HI, 32'h0);
    expect_read(OFF_VS2_0, 32'h0);
    expect_read(OFF_VS2_1, 32'h0);
    expect_read(OFF_VS2_2, 32'h0);
    expect_read(OFF_VS2_3, 32'h0);
    expect_read(OFF_STATUS, 32'h0);
    expect_read(OFF_RES_LO, 32'h0);
    expect_read(OFF_RES_HI, 32'h0);
  endtask

  task automatic register_readback();
    axil_write(OFF_CFG, 32'hFFFF_FFFF, 0);
    expect_read(OFF_CFG, 32'h0000_000F);  // Only op and sew stored
    axil_write(OFF_CFG, 32'h0000_0006, 0);
    expect_read(OFF_CFG, 32'h0000_0006);
    axil_write(OFF_SCALAR_LO, 32'h1234_5678, 0);
    axil_write(OFF_SCALAR_HI, 32'h9ABC_DEF0, 0);
    axil_write(OFF_VS2_0, 32'h0101_0101, 0);
    axil_write(OFF_VS2_1, 32'hA5A5_5A5A, 0);
    axil_write(OFF_VS2_2, 32'hDEAD_BEEF, 0);
    axil_write(OFF_VS2_3, 32'h8000_0001, 0);
    expect_read(OFF_SCALAR_LO, 32'h1234_5678);
    expect_read(OFF_SCALAR_HI, 32'h9ABC_DEF0);
    expect_read(OFF_VS2_0, 32'h0101_0101);
    expect_read(OFF_VS2_1, 32'hA5A5_5A5A);
    expect_read(OFF_VS2_2, 32'hDEAD_BEEF);
    expect_read(OFF_VS2_3, 32'h8000_0001);
    // Unmapped and write-only offsets
    expect_read(8'h0C, 32'h0);
    expect_read(OFF_START, 32'h0);
    expect_read(8'h30, 32'h0);
    expect_read(8'h3C, 32'h0);
  endtask

  task automatic width_sweep();
    run_reduction(RED_SUM, SEW_8, 64'hF0, 128'hFFEE_DDCC_BBAA_9988_7766_5544_3322_1100);
    run_reduction(RED_SUM, SEW_16, 64'hFFFF, 128'h8000_7FFF_FFFF_0001_1234_EDCB_FFFE_0003);
    run_reduction(RED_SUM, SEW_32, 64'hFFFF_FFF0,
                  128'hFFFF_FFFF_8000_0000_8000_0001_0000_0010);
    run_reduction(RED_SUM, SEW_64, 64'hFFFF_FFFF_FFFF_FFFF,
                  128'h8000_0000_0000_0001_8000_0000_0000_0002);
    run_reduction(RED_AND, SEW_16, 64'hFFFF, 128'hFFF7_FFFF_FF7F_FFFF_FFFF_F7FF_FFFF_FFFE);
    run_reduction(RED_AND, SEW_64, 64'hF0F0_FFFF_FFFF_0F0F,
                  128'hFFFF_0FFF_FFFF_FFFF_FFFF_FFFF_FFF0_FFFF);
    run_reduction(RED_OR, SEW_8, 64'h01, 128'h0000_0200_0000_0004_0000_1000_0000_0040);
    run_reduction(RED_OR, SEW_32, 64'hDEAD_0000_8000_0000,
                  128'h0000_0001_0000_0100_0001_0000_0100_0000);
    run_reduction(RED_XOR, SEW_16, 64'hA5A5, 128'h1111_2222_3333_4444_5555_6666_7777_8888);
    run_reduction(RED_XOR, SEW_32, 64'h1234_5678_9ABC_DEF0,
                  128'hFFFF_0000_0000_FFFF_AAAA_5555_5555_AAAA);
  endtask

  task automatic random_reductions();
    red_op_t op;
    sew_t    sew;
    elem_t   scalar;
    vec_t    vec;
    for (int i = 0; i < 20; i++) begin
      op     = red_op_t'($urandom_range(3, 0));
      sew    = sew_t'($urandom_range(3, 0));
      scalar = {$urandom, $urandom};
      vec    = {$urandom, $urandom, $urandom, $urandom};
      run_reduction(op, sew, scalar, vec);
    end
  endtask

  task automatic back_pressure();
    word_t status;
    elem_t res;
    load_operands(RED_SUM, SEW_16, 64'h7FFF, 128'hFFFF_8001_1234_4321_0F0F_F0F0_AAAA_5555);
    axil_write(OFF_START, 32'h0, 6);  // Reduction finishes while bready is low
    axil_read(OFF_STATUS, 5, status);
    check_word("STATUS after stalled START", status, 32'h2);
    read_result(6, res);
    check_result("stalled read", res,
                 ref_fold(RED_SUM, SEW_16, 64'h7FFF,
                          128'hFFFF_8001_1234_4321_0F0F_F0F0_AAAA_5555));
    run_reduction(RED_XOR, SEW_8, 64'h3C, 128'h0102_0408_1020_4080_FFFE_FDFB_F7EF_DFBF);
  endtask

  task automatic done_flag_cycle();
    word_t status;
    elem_t res;
    run_reduction(RED_OR, SEW_64, 64'h1, 128'h8000_0000_0000_0000_0000_0000_0000_0100);
    expect_read(OFF_STATUS, 32'h2);
    axil_write(OFF_START, 32'h0, 0);
    axil_read(OFF_STATUS, 0, status);
    check_word("STATUS done bit after START", status & 32'h2, 32'h0);
    wait_done();
    expect_read(OFF_STATUS, 32'h2);
    read_result(0, res);
    check_result("repeat START", res,
                 ref_fold(RED_OR, SEW_64, 64'h1, 128'h8000_0000_0000_0000_0000_0000_0000_0100));
  endtask

  ////////////////////////////////////////////////////////////
  // Timeout, assertion watch and main sequence
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (vred_top_inst.vred_properties_inst.fail_count != 0) begin
      $display("An assertion bound into vred_top failed");
      abort_run("assertion failure");
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      abort_run("timeout");
    end
  end

  initial begin
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    void'($urandom(32'hf7cd));
    @(posedge rstn);
    next_cycle();

    reset_values();
    register_readback();
    width_sweep();
    random_reductions();
    back_pressure();
    done_flag_cycle();

    if (vred_top_inst.vred_properties_inst.fail_count != 0) begin
      $display("Assertion checks failed %0d times",
               vred_top_inst.vred_properties_inst.fail_count);
      abort_run("assertion failures");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- src.f
logic/vred_pkg.sv
logic/vred_unit.sv
logic/vred_ctrl.sv
logic/vred_axil_regs.sv
logic/vred_top.sv
testbench/tb_clock_gen.sv
testbench/vred_properties.sv
testbench/tb_vred_top.sv

//--- Bender.yml
package:
  name: vred

sources:
  # RTL in compile order
  - files:
      - logic/vred_pkg.sv
      - logic/vred_unit.sv
      - logic/vred_ctrl.sv
      - logic/vred_axil_regs.sv
      - logic/vred_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/vred_properties.sv
      - testbench/tb_vred_top.sv
